/* project.f */
design/hsid_cfg_pkg.sv
design/hsid_ctrl_pkg.sv
design/hsid_elem_if.sv
design/hsid_measure_buf.sv
design/hsid_ref_ingress.sv
design/hsid_main_fsm.sv
design/hsid_sse_unit.sv
design/hsid_min_select.sv
design/hsid_top.sv
dv/hsid_sva.sv
dv/hsid_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module hsid_tb \
  -f project.f -o hsid_sim \
  && ./obj_dir/hsid_sim > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* dv/hsid_tb.sv */
module hsid_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BANDS       = 8;
  localparam int ELEMS       = BANDS / 2;  // Words per spectrum
  localparam int LIB_MAX     = 16;
  localparam int FIFO_DEPTH  = 4;          // Sender credits after reset
  localparam int TIMEOUT_CYC = 4000;       // About four times the longest test sequence

  logic                   clk;
  logic                   rst_n;
  logic                   start;
  hsid_cfg_pkg::lib_idx_t lib_size;
  logic                   meas_valid;
  hsid_cfg_pkg::elem_t    meas_data;
  logic                   ref_valid;
  hsid_cfg_pkg::elem_t    ref_data;
  logic                   ref_credit;
  hsid_cfg_pkg::lib_idx_t best_idx;
  hsid_cfg_pkg::score_t   best_score;
  logic                   done;
  logic                   idle;
  logic                   ready;

  hsid_cfg_pkg::elem_t meas_vec [ELEMS];           // Measured pixel
  hsid_cfg_pkg::elem_t lib_mem  [LIB_MAX][ELEMS];  // Reference library
  int errors     = 0;
  int checks     = 0;
  int cycles     = 0;
  int done_cnt   = 0;  // done pulses seen
  int runs       = 0;  // Starts issued
  int sent_total = 0;  // Reference words pushed
  int credit_ret = 0;  // ref_credit pulses seen

  hsid_top #(
    .HSI_BANDS      (BANDS),
    .LIB_SIZE       (LIB_MAX),
    .REF_FIFO_DEPTH (FIFO_DEPTH)
  ) i_hsid_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .lib_size   (lib_size),
    .meas_valid (meas_valid),
    .meas_data  (meas_data),
    .ref_valid  (ref_valid),
    .ref_data   (ref_data),
    .ref_credit (ref_credit),
    .best_idx   (best_idx),
    .best_score (best_score),
    .done       (done),
    .idle       (idle),
    .ready      (ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Pulse counters and run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (done) done_cnt <= done_cnt + 1;
    if (ref_credit) credit_ret <= credit_ret + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, the DUT never finished its run", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input longint exp, input longint act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // Sum of squared band differences, both bands of every word
  function automatic longint ref_sse(input int v);
    longint sum;
    longint d;
    sum = 0;
    for (int e = 0; e < ELEMS; e++) begin
      for (int h = 0; h < 2; h++) begin
        d = longint'(meas_vec[e][16*h +: 16]) - longint'(lib_mem[v][e][16*h +: 16]);
        sum += d * d;
      end
    end
    return sum;
  endfunction

  function automatic void model_best(input int n, output int idx, output longint score);
    longint s;
    idx   = 0;
    score = ref_sse(0);
    for (int v = 1; v < n; v++) begin
      s = ref_sse(v);
      if (s < score) begin  // Strictly lower, ties keep the earlier index
        idx   = v;
        score = s;
      end
    end
  endfunction

  task automatic fill_random(input int n);
    for (int e = 0; e < ELEMS; e++) meas_vec[e] = $urandom();
    for (int v = 0; v < n; v++) begin
      for (int e = 0; e < ELEMS; e++) lib_mem[v][e] = $urandom();
    end
  endtask

  task automatic load_measure();
    do @(posedge clk); while (!ready);  // Only send while ready
    for (int e = 0; e < ELEMS; e++) begin
      meas_valid <= 1'b1;
      meas_data  <= meas_vec[e];
      @(posedge clk);
    end
    meas_valid <= 1'b0;
  endtask

  // One word per credit, random idle gaps
  task automatic send_refs(input int n, input int gap_max);
    int gap;
    for (int v = 0; v < n; v++) begin
      for (int e = 0; e < ELEMS; e++) begin
        gap = $urandom_range(gap_max, 0);
        ref_valid <= 1'b0;
        repeat (gap) @(posedge clk);
        while (sent_total - credit_ret >= FIFO_DEPTH) @(posedge clk);  // Out of credits
        ref_valid  <= 1'b1;
        ref_data   <= lib_mem[v][e];
        sent_total++;
        @(posedge clk);
      end
    end
    ref_valid <= 1'b0;
  endtask

  task automatic check_result(input int n);
    int     exp_idx;
    longint exp_score;
    model_best(n, exp_idx, exp_score);
    check_val("best_idx", exp_idx, best_idx);
    check_val("best_score", exp_score, best_score);
  endtask

  task automatic run_search(input int n, input int gap_max);
    int done_before;
    done_before = done_cnt;
    lib_size <= hsid_cfg_pkg::lib_idx_t'(n);
    start    <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    runs++;
    fork
      load_measure();
      send_refs(n, gap_max);
    join
    do @(posedge clk); while (!done);  // Global counter bounds this wait
    check_result(n);
    @(posedge clk);
    check_val("done_cnt", 1, done_cnt - done_before);  // Exactly one pulse per run
  endtask

  task automatic reset_idle_check();
    check_val("idle", 1, idle);
    check_val("ready", 0, ready);
    check_val("done", 0, done);
    check_val("ref_credit", 0, ref_credit);
    repeat (20) @(posedge clk);  // No start, so nothing may finish
    check_val("done_cnt", 0, done_cnt);
    check_val("idle", 1, idle);
  endtask

  task automatic exact_match();
    int idx;
    idx = $urandom_range(LIB_MAX - 1, 0);
    fill_random(LIB_MAX);
    for (int e = 0; e < ELEMS; e++) lib_mem[idx][e] = meas_vec[e];  // Planted copy
    run_search(LIB_MAX, 1);
    check_val("best_idx", idx, best_idx);
    check_val("best_score", 0, best_score);
  endtask

  task automatic nearest_ref();
    fill_random(LIB_MAX);
    run_search(LIB_MAX, 0);  // Sender at full credit rate
  endtask

  task automatic credit_flow();
    int sent_before;
    int ret_before;
    fill_random(12);
    sent_before = sent_total;
    ret_before  = credit_ret;
    run_search(12, 3);
    repeat (4) @(posedge clk);
    check_val("ref_credit pulses", sent_total - sent_before, credit_ret - ret_before);
  endtask

  task automatic tie_rule();
    int lo;
    int hi;
    lo = $urandom_range(4, 0);
    hi = $urandom_range(9, 5);
    fill_random(10);
    for (int e = 0; e < ELEMS; e++) begin
      lib_mem[lo][e] = meas_vec[e] ^ 32'h0001_0001;  // Each band off by one
      lib_mem[hi][e] = lib_mem[lo][e];
    end
    run_search(10, 1);
    check_val("best_idx", lo, best_idx);
  endtask

  task automatic back_to_back();
    fill_random(5);
    run_search(5, 0);
    fill_random(13);
    run_search(13, 2);  // Different library size
  endtask

  initial begin
    void'($urandom(32'ha94a));
    rst_n      = 1'b0;
    start      = 1'b0;
    lib_size   = '0;
    meas_valid = 1'b0;
    meas_data  = '0;
    ref_valid  = 1'b0;
    ref_data   = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    reset_idle_check();
    exact_match();
    nearest_ref();
    credit_flow();
    tie_rule();
    back_to_back();
    repeat (10) @(posedge clk);
    check_val("done_cnt", runs, done_cnt);  // No stray pulses
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dv/hsid_sva.sv */
module hsid_sva (
  input logic                            clk,
  input logic                            rst_n,
  input hsid_ctrl_pkg::hsid_main_state_t state,
  input logic                            meas_valid,
  input logic                            done,
  input logic                            idle,
  input logic                            ready,
  input logic                            ref_credit
);
  timeunit 1ns;
  timeprecision 1ps;

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  idle_not_done: assert property (@(posedge clk) disable iff (!rst_n) !(idle && done))
    else $error("idle and done high together");

  ready_not_done: assert property (@(posedge clk) disable iff (!rst_n) !(ready && done))
    else $error("ready and done high together");

  // Nothing popped while in reset
  credit_in_reset: assert property (@(posedge clk) !rst_n |-> !ref_credit)
    else $error("ref_credit pulsed during reset");

  // Sender keeps measured words inside the load window
  meas_in_load: assert property (@(posedge clk) disable iff (!rst_n)
                                 meas_valid |-> (state == hsid_ctrl_pkg::READ_MEASURE))
    else $error("meas_valid driven outside the measured pixel load");

endmodule

bind hsid_top hsid_sva i_hsid_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .state      (state),
  .meas_valid (meas_valid),
  .done       (done),
  .idle       (idle),
  .ready      (ready),
  .ref_credit (ref_credit)
);

/* design/hsid_top.sv */
module hsid_top #(
  parameter int HSI_BANDS      = hsid_cfg_pkg::hsid_bands_dflt,
  parameter int LIB_SIZE       = hsid_cfg_pkg::hsid_lib_dflt,
  parameter int REF_FIFO_DEPTH = hsid_cfg_pkg::hsid_fifo_depth_dflt
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Control
  input  logic                   start,
  input  hsid_cfg_pkg::lib_idx_t lib_size,
  // Measured pixel stream
  input  logic                   meas_valid,
  input  hsid_cfg_pkg::elem_t    meas_data,
  // Reference stream, credit based
  input  logic                   ref_valid,
  input  hsid_cfg_pkg::elem_t    ref_data,
  output logic                   ref_credit,
  // Result
  output hsid_cfg_pkg::lib_idx_t best_idx,
  output hsid_cfg_pkg::score_t   best_score,
  output logic                   done,
  output logic                   idle,
  output logic                   ready
);

  localparam int ELEMENTS = HSI_BANDS / 2;  // Two bands per word

  hsid_ctrl_pkg::hsid_main_state_t state;
  logic                 run_start;         // Start accepted in IDLE
  logic                 measure_complete;
  logic                 ref_empty;
  logic                 both_read_en;
  logic                 score_valid;
  hsid_cfg_pkg::score_t score;
  logic                 score_last;
  logic                 sse_done;          // Final score of the run
  logic                 cmp_valid;

  hsid_elem_if elem_bus ();

  assign run_start = start && idle;        // Ignore start while busy
  assign sse_done  = score_valid && score_last;

  hsid_measure_buf #(
    .ELEMENTS (ELEMENTS)
  ) i_measure_buf (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (run_start),
    .wr_en    (meas_valid && ready),
    .wr_data  (meas_data),
    .rd_en    (both_read_en),
    .complete (measure_complete),
    .rd_data  (elem_bus.meas)
  );

  hsid_ref_ingress #(
    .DEPTH (REF_FIFO_DEPTH)
  ) i_ref_ingress (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ref_valid),
    .push_data (ref_data),
    .pop       (both_read_en),
    .empty     (ref_empty),
    .pop_data  (elem_bus.ref_word),
    .credit    (ref_credit)
  );

  hsid_main_fsm #(
    .ELEMENTS (ELEMENTS),
    .LIB_SIZE (LIB_SIZE)
  ) i_main_fsm (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (run_start),
    .lib_size         (lib_size),
    .measure_complete (measure_complete),
    .ref_empty        (ref_empty),
    .sse_done         (sse_done),
    .cmp_valid        (cmp_valid),
    .state            (state),
    .both_read_en     (both_read_en),
    .ready            (ready),
    .idle             (idle),
    .done             (done),
    .elem             (elem_bus.source)
  );

  hsid_sse_unit #(
    .ELEMENTS (ELEMENTS)
  ) i_sse_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .vector_total (lib_size),
    .elem         (elem_bus.sink),
    .score_valid  (score_valid),
    .score        (score),
    .score_last   (score_last)
  );

  hsid_min_select i_min_select (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (run_start),
    .score_valid (score_valid),
    .score       (score),
    .score_last  (score_last),
    .best_idx    (best_idx),
    .best_score  (best_score),
    .cmp_valid   (cmp_valid)
  );

endmodule

/* design/hsid_min_select.sv */
module hsid_min_select (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,        // New run
  input  logic                   score_valid,
  input  hsid_cfg_pkg::score_t   score,
  input  logic                   score_last,
  output hsid_cfg_pkg::lib_idx_t best_idx,
  output hsid_cfg_pkg::score_t   best_score,
  output logic                   cmp_valid     // Result final
);

  hsid_cfg_pkg::lib_idx_t score_idx;  // Library index of the arriving score
  logic                   take;       // New best

  // First score always wins, later ones only if strictly lower
  assign take = (score_idx == '0) || (score < best_score);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_idx  <= '0;
      best_idx   <= '0;
      best_score <= '1;
      cmp_valid  <= 1'b0;
    end else begin
      cmp_valid <= score_valid && score_last;  // One cycle after last score
      if (start) begin
        score_idx  <= '0;
        best_idx   <= '0;
        best_score <= '1;
      end else if (score_valid) begin
        score_idx <= score_last ? '0 : score_idx + 1'b1;
        if (take) begin
          best_idx   <= score_idx;
          best_score <= score;
        end
      end
    end
  end

endmodule

/* design/hsid_sse_unit.sv */
module hsid_sse_unit #(
  parameter int ELEMENTS = 64  // Words per spectrum, sizes the accumulator
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  hsid_cfg_pkg::lib_idx_t vector_total,  // References this run
  hsid_elem_if.sink              elem,
  output logic                   score_valid,
  output hsid_cfg_pkg::score_t   score,
  output logic                   score_last     // Final reference of the run
);

  localparam int ACC_W = 34 + $clog2(ELEMENTS);  // Pair sum plus growth

  hsid_cfg_pkg::band_t      meas_lo, meas_hi, ref_lo, ref_hi;
  logic signed [16:0]       diff_lo, diff_hi;   // Band differences
  logic signed [33:0]       sq_lo, sq_hi;
  logic        [33:0]       pair_sum;           // Both squares of one word
  logic        [33:0]       s1_sum;
  logic                     s1_valid, s1_start, s1_last;
  logic        [ACC_W-1:0]  acc;                // Running sum of one reference
  logic        [ACC_W-1:0]  acc_next;
  hsid_cfg_pkg::lib_idx_t   vec_cnt;            // Scores emitted this run
  logic                     vec_end;

  // Split both words into bands
  assign meas_lo = elem.meas[15:0];
  assign meas_hi = elem.meas[31:16];
  assign ref_lo  = elem.ref_word[15:0];
  assign ref_hi  = elem.ref_word[31:16];

  assign diff_lo  = $signed({1'b0, meas_lo}) - $signed({1'b0, ref_lo});
  assign diff_hi  = $signed({1'b0, meas_hi}) - $signed({1'b0, ref_hi});
  assign sq_lo    = diff_lo * diff_lo;
  assign sq_hi    = diff_hi * diff_hi;
  assign pair_sum = $unsigned(sq_lo) + $unsigned(sq_hi);  // Both non-negative

  // Restart on first word so vectors stream back to back
  assign acc_next = (s1_start ? '0 : acc) + ACC_W'(s1_sum);
  assign vec_end  = (vec_cnt == vector_total - hsid_cfg_pkg::lib_idx_t'(1));

  // Stage one flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_start <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= elem.valid;
      s1_start <= elem.valid && elem.start;
      s1_last  <= elem.valid && elem.last;
    end
  end

  always_ff @(posedge clk) begin
    if (elem.valid) s1_sum <= pair_sum;     // Squared terms at t+2
    if (s1_valid && s1_last) score <= hsid_cfg_pkg::score_t'(acc_next);
  end

  // Stage two accumulate and emit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc         <= '0;
      vec_cnt     <= '0;
      score_valid <= 1'b0;
      score_last  <= 1'b0;
    end else begin
      score_valid <= s1_valid && s1_last;  // Score out at t+3
      score_last  <= s1_valid && s1_last && vec_end;
      if (s1_valid) acc <= acc_next;
      if (s1_valid && s1_last) begin
        vec_cnt <= vec_end ? '0 : vec_cnt + 1'b1;  // Wraps for the next run
      end
    end
  end

endmodule

/* design/hsid_main_fsm.sv */
module hsid_main_fsm #(
  parameter int ELEMENTS = 64,   // Words per spectrum
  parameter int LIB_SIZE = 256   // Largest library a run may use
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  hsid_cfg_pkg::lib_idx_t           lib_size,          // References this run
  input  logic                             measure_complete,
  input  logic                             ref_empty,
  input  logic                             sse_done,          // Final score out
  input  logic                             cmp_valid,         // Minimum settled
  output hsid_ctrl_pkg::hsid_main_state_t  state,
  output logic                             both_read_en,      // Pop both buffers
  output logic                             ready,
  output logic                             idle,
  output logic                             done,
  hsid_elem_if.source                      elem               // Flag side only
);

  localparam int EW = (ELEMENTS > 1) ? $clog2(ELEMENTS) : 1;
  localparam int VW = $clog2(LIB_SIZE + 1);  // Enough for LIB_SIZE - 1

  hsid_ctrl_pkg::hsid_main_state_t next_state;
  logic [EW-1:0] elem_cnt;   // Word within current reference
  logic [VW-1:0] vec_cnt;    // Reference being read
  logic          elem_end;   // Last word of a reference
  logic          vec_end;    // Last reference of the library
  logic          run_go;     // Leaving IDLE

  assign elem_end = (elem_cnt == EW'(ELEMENTS - 1));
  assign vec_end  = (hsid_cfg_pkg::lib_idx_t'(vec_cnt)
                     == lib_size - hsid_cfg_pkg::lib_idx_t'(1));
  assign run_go   = (state == hsid_ctrl_pkg::IDLE) && start;

  // Measured side is always full here, so only the FIFO gates reads
  assign both_read_en = (state == hsid_ctrl_pkg::COMPUTE_MSE) && !ref_empty;

  // Block handshake decoded from state
  assign idle  = (state == hsid_ctrl_pkg::IDLE);
  assign ready = (state == hsid_ctrl_pkg::READ_MEASURE);
  assign done  = (state == hsid_ctrl_pkg::DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= hsid_ctrl_pkg::IDLE;
      elem_cnt   <= '0;
      vec_cnt    <= '0;
      elem.valid <= 1'b0;
      elem.start <= 1'b0;
      elem.last  <= 1'b0;
    end else begin
      state      <= next_state;
      // Flags line up with the registered read data
      elem.valid <= both_read_en;
      elem.start <= both_read_en && (elem_cnt == '0);
      elem.last  <= both_read_en && elem_end;
      if (run_go) begin
        elem_cnt <= '0;                    // Fresh counts per run
        vec_cnt  <= '0;
      end else if (both_read_en) begin
        if (elem_end) begin
          elem_cnt <= '0;
          vec_cnt  <= vec_cnt + 1'b1;      // Next reference
        end else begin
          elem_cnt <= elem_cnt + 1'b1;
        end
      end
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      hsid_ctrl_pkg::IDLE: begin
        if (start) next_state = hsid_ctrl_pkg::READ_MEASURE;
      end
      hsid_ctrl_pkg::READ_MEASURE: begin
        if (measure_complete) next_state = hsid_ctrl_pkg::COMPUTE_MSE;
      end
      hsid_ctrl_pkg::COMPUTE_MSE: begin
        // Stop right after the final word is read
        if (both_read_en && elem_end && vec_end) next_state = hsid_ctrl_pkg::WAIT_MSE;
      end
      hsid_ctrl_pkg::WAIT_MSE: begin
        if (sse_done) next_state = hsid_ctrl_pkg::COMPARE_MSE;
      end
      hsid_ctrl_pkg::COMPARE_MSE: begin
        if (cmp_valid) next_state = hsid_ctrl_pkg::DONE;
      end
      hsid_ctrl_pkg::DONE: begin
        next_state = hsid_ctrl_pkg::IDLE;  // Single-cycle pulse
      end
      default: begin
        next_state = hsid_ctrl_pkg::IDLE;
      end
    endcase
  end

endmodule

/* design/hsid_ref_ingress.sv */
module hsid_ref_ingress #(
  parameter int DEPTH = 16  // Entries, equal to the sender's credits
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push,
  input  hsid_cfg_pkg::elem_t push_data,
  input  logic                pop,
  output logic                empty,
  output hsid_cfg_pkg::elem_t pop_data,
  output logic                credit     // One slot freed
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  hsid_cfg_pkg::elem_t mem [DEPTH];  // Reference word store
  logic [AW-1:0]       wr_ptr;
  logic [AW-1:0]       rd_ptr;
  logic [CW-1:0]       count;           // Entries held
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign empty   = (count == '0);
  assign full    = (count == CW'(DEPTH));
  assign do_push = push && (!full || pop);  // Credits keep this from dropping
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= do_pop;                 // Credit back one cycle after read
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
    if (do_pop) pop_data <= mem[rd_ptr];  // Registered read
  end

endmodule

/* design/hsid_measure_buf.sv */
module hsid_measure_buf #(
  parameter int ELEMENTS = 64  // Words per spectrum
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,     // New run, forget the old pixel
  input  logic                wr_en,
  input  hsid_cfg_pkg::elem_t wr_data,
  input  logic                rd_en,
  output logic                complete,  // Whole vector stored
  output hsid_cfg_pkg::elem_t rd_data
);

  localparam int AW = (ELEMENTS > 1) ? $clog2(ELEMENTS) : 1;

  hsid_cfg_pkg::elem_t mem [ELEMENTS];  // Measured pixel store
  logic [AW-1:0]       wr_ptr;
  logic [AW-1:0]       rd_ptr;
  logic                wr_ok;              // Write accepted
  logic                wr_end;             // Writing the final word
  logic                rd_end;             // Reading the final word

  assign wr_ok  = wr_en && !complete;       // Ignore extra words once full
  assign wr_end = (wr_ptr == AW'(ELEMENTS - 1));
  assign rd_end = (rd_ptr == AW'(ELEMENTS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      complete <= 1'b0;
    end else if (start) begin
      wr_ptr   <= '0;                      // Fresh fill for this run
      rd_ptr   <= '0;
      complete <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_end ? '0 : wr_ptr + 1'b1;
        if (wr_end) complete <= 1'b1;      // Buffer full
      end
      if (rd_en) begin
        rd_ptr <= rd_end ? '0 : rd_ptr + 1'b1;  // Replay per reference
      end
    end
  end

  // Storage and read register
  always_ff @(posedge clk) begin
    if (wr_ok) mem[wr_ptr] <= wr_data;
    if (rd_en) rd_data <= mem[rd_ptr];     // Valid the cycle after rd_en
  end

endmodule

/* design/hsid_elem_if.sv */
interface hsid_elem_if;

  logic                valid;     // Pair below is live this cycle
  logic                start;     // First element of a reference vector
  logic                last;      // Final element of a reference vector
  hsid_cfg_pkg::elem_t meas;      // Measured pixel word
  hsid_cfg_pkg::elem_t ref_word;  // Matching reference word

  // Flags come from the FSM, words from the two input buffers
  modport source (
    output valid,
    output start,
    output last,
    output meas,
    output ref_word
  );

  // Scoring pipeline side
  modport sink (
    input valid,
    input start,
    input last,
    input meas,
    input ref_word
  );

endinterface

/* design/hsid_ctrl_pkg.sv */
package hsid_ctrl_pkg;

  // Run control states
  typedef enum logic [2:0] {
    IDLE,          // Waiting for start
    READ_MEASURE,  // Loading the measured pixel
    COMPUTE_MSE,   // Streaming references through the scorer
    WAIT_MSE,      // Draining the score pipeline
    COMPARE_MSE,   // Minimum selector finishing
    DONE           // One-cycle completion
  } hsid_main_state_t;

endpackage

/* design/hsid_cfg_pkg.sv */
package hsid_cfg_pkg;

  // Default sizes for the top level
  localparam int hsid_bands_dflt      = 128;  // Spectral bands per pixel
  localparam int hsid_lib_dflt        = 256;  // Reference library capacity
  localparam int hsid_fifo_depth_dflt = 16;   // Reference FIFO entries, also sender credits

  // One spectral sample
  typedef logic [15:0] band_t;

  // Two bands per word, lower band in bits 15:0
  typedef logic [31:0] elem_t;

  // Sum of squared band errors for one reference
  typedef logic [47:0] score_t;

  // Library index, also used for library size
  typedef logic [15:0] lib_idx_t;

endpackage
